//--- hdl/sum_pkg.sv
`default_nettype none

package sum_pkg;

	// top level defaults, the testbench builds its stimulus from these too
	localparam int LANES_DEF    = 16;	// samples per beat
	localparam int SAMPLE_W_DEF = 16;	// unsigned sample width
	localparam int ACC_W_DEF    = 40;	// running total, 20b tree sum + 20b beat count
	localparam int TARGET_W     = 20;	// beat target and beat counter
	localparam int APB_AW       = 5;	// byte address, six word registers
	localparam int APB_DW       = 32;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;	// tied high, no wait states
		logic              pslverr;
	} apb_rsp_t;

	// register map, byte offsets
	typedef enum logic [APB_AW-1:0] {
		REG_CTRL      = 5'h00,	// wo, bit0 start
		REG_TARGET    = 5'h04,	// rw, beats to sum
		REG_STATUS    = 5'h08,	// ro, {overrun, done, busy}
		REG_RESULT_LO = 5'h0C,	// ro
		REG_RESULT_HI = 5'h10,	// ro, upper 8 bits
		REG_BEATS     = 5'h14	// ro
	} reg_addr_e;

	typedef struct packed {
		logic                start;	// one cycle
		logic [TARGET_W-1:0] target;
	} acc_ctrl_t;

	typedef struct packed {
		logic                 busy;
		logic                 done;
		logic                 overrun;
		logic [ACC_W_DEF-1:0] result;
		logic [TARGET_W-1:0]  beats;
	} acc_status_t;

	typedef enum logic [1:0] {
		ACC_IDLE,
		ACC_RUN,
		ACC_DONE
	} acc_state_e;

endpackage

`default_nettype wire

//--- hdl/reduction_stage.sv
`timescale 1ns/1ps
`default_nettype none

// one pipeline level of an adder tree
// every REDUCTION neighbouring input words collapse into one wider output word
module reduction_stage #(
	parameter int IN_WORD_WIDTH  = 16,
	parameter int OUT_WORD_WIDTH = 18,	// should be IN_WORD_WIDTH + clog2(REDUCTION) or more
	parameter int IN_BLOCKS      = 16,
	parameter int REDUCTION      = 4,
	localparam int OUT_BLOCKS    = (IN_BLOCKS + REDUCTION - 1) / REDUCTION	// round up
) (
	input wire                                 clk,
	input wire                                 rst,
	input wire                                 en,	// din qualifier
	input wire [IN_WORD_WIDTH*IN_BLOCKS-1:0]   din,	// word 0 in the low bits
	output logic                               dout_valid,
	output logic [OUT_WORD_WIDTH*OUT_BLOCKS-1:0] dout
);

	logic [OUT_WORD_WIDTH*OUT_BLOCKS-1:0] sum_comb;	// group sums ahead of the register

	always_comb begin
		sum_comb = '0;
		for (int i = 0; i < OUT_BLOCKS; i++) begin
			for (int j = 0; j < REDUCTION; j++) begin
				// a short last group only picks up the words that exist
				if (i*REDUCTION + j < IN_BLOCKS) begin
					sum_comb[i*OUT_WORD_WIDTH +: OUT_WORD_WIDTH] =
						sum_comb[i*OUT_WORD_WIDTH +: OUT_WORD_WIDTH] +
						OUT_WORD_WIDTH'(din[(i*REDUCTION + j)*IN_WORD_WIDTH +: IN_WORD_WIDTH]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= en;	// follows data by exactly one clock
		end
	end

	// payload, qualified by dout_valid downstream
	always_ff @(posedge clk) begin
		dout <= sum_comb;
	end

endmodule

`default_nettype wire

//--- hdl/beat_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

// sums a programmed number of tree results into one wide total
module beat_accumulator import sum_pkg::*; #(
	parameter int SUM_W = 20,	// tree output width
	parameter int ACC_W = ACC_W_DEF	// SUM_W + TARGET_W keeps a full run from wrapping
) (
	input wire              clk,
	input wire              rst,
	input wire              tree_valid,
	input wire [SUM_W-1:0]  tree_sum,
	input wire acc_ctrl_t   ctrl,
	output acc_status_t     status
);

	acc_state_e          state;
	logic [ACC_W-1:0]    acc;	// running total
	logic [TARGET_W-1:0] beats;	// tree results taken this run
	logic [TARGET_W-1:0] beats_nxt;
	logic                overrun;	// sticky until next start

	assign beats_nxt = beats + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= ACC_IDLE;
			acc     <= '0;
			beats   <= '0;
			overrun <= 1'b0;
		end else if (ctrl.start) begin
			// start wins over an arriving result, so a restart drops the partial sum
			acc     <= '0;
			beats   <= '0;
			overrun <= 1'b0;
			if (ctrl.target == '0) begin
				state <= ACC_DONE;	// nothing to sum
			end else begin
				state <= ACC_RUN;
			end
		end else if (tree_valid) begin
			case (state)
				ACC_RUN: begin
					acc   <= acc + ACC_W'(tree_sum);
					beats <= beats_nxt;
					if (beats_nxt == ctrl.target) begin
						state <= ACC_DONE;	// last beat lands on this edge
					end
				end
				default: begin
					overrun <= 1'b1;	// no run open, the beat is lost
				end
			endcase
		end
	end

	always_comb begin
		status.busy    = (state == ACC_RUN);
		status.done    = (state == ACC_DONE);
		status.overrun = overrun;
		status.result  = ACC_W_DEF'(acc);
		status.beats   = beats;
	end

	// the count must reach target and stop there, target comes from the register block
	a_beats_below_target: assert property (@(posedge clk) disable iff (rst)
		state == ACC_RUN |-> beats < ctrl.target);

	// start is decoded from one APB access cycle, and a setup phase always separates two
	a_start_pulse: assert property (@(posedge clk) disable iff (rst)
		ctrl.start |=> !ctrl.start);

endmodule

`default_nettype wire

//--- hdl/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

// zero wait state APB slave for control and readback
module apb_regs import sum_pkg::*; (
	input wire                clk,
	input wire                rst,
	input wire apb_req_t      apb_req,
	output apb_rsp_t          apb_rsp,
	output acc_ctrl_t         ctrl,
	input wire acc_status_t   status
);

	reg_addr_e           addr;
	logic                access;	// second phase of a transfer
	logic                mapped;
	logic                writable;
	logic                err;
	logic                wr_en;
	logic [TARGET_W-1:0] target;
	logic [APB_DW-1:0]   rdata;

	assign addr   = reg_addr_e'(apb_req.paddr);	// unaligned offsets fall to default below
	assign access = apb_req.psel & apb_req.penable;

	// address decode and read mux
	always_comb begin
		mapped   = 1'b1;
		writable = 1'b0;
		rdata    = '0;
		case (addr)
			REG_CTRL: begin
				writable = 1'b1;	// reads back zero
			end
			REG_TARGET: begin
				writable = 1'b1;
				rdata    = APB_DW'(target);
			end
			REG_STATUS: begin
				rdata = APB_DW'({status.overrun, status.done, status.busy});
			end
			REG_RESULT_LO: begin
				rdata = status.result[APB_DW-1:0];
			end
			REG_RESULT_HI: begin
				rdata = APB_DW'(status.result >> APB_DW);	// top 8 bits
			end
			REG_BEATS: begin
				rdata = APB_DW'(status.beats);
			end
			default: begin
				mapped = 1'b0;
			end
		endcase
	end

	// error on unmapped offsets and on writes to read only registers
	assign err   = access & (~mapped | (apb_req.pwrite & ~writable));
	assign wr_en = access & apb_req.pwrite & ~err;

	always_ff @(posedge clk) begin
		if (rst) begin
			target <= '0;
		end else if (wr_en && addr == REG_TARGET) begin
			target <= apb_req.pwdata[TARGET_W-1:0];	// upper bits ignored
		end
	end

	// start leaves in the access cycle so the run opens on the same edge as the write
	assign ctrl.start  = wr_en & (addr == REG_CTRL) & apb_req.pwdata[0];
	assign ctrl.target = target;

	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = err;
		if (access && !apb_req.pwrite && !err) begin
			apb_rsp.prdata = rdata;
		end else begin
			apb_rsp.prdata = '0;
		end
	end

	a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
		apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

//--- hdl/sum_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

// streaming sum engine
// two stage adder tree, beat accumulator and APB register block
module sum_engine_top import sum_pkg::*; #(
	parameter int LANES    = LANES_DEF,
	parameter int SAMPLE_W = SAMPLE_W_DEF,
	parameter int ACC_W    = ACC_W_DEF
) (
	input wire                        clk,
	input wire                        rst,
	input wire                        sample_valid,	// no ready, taken every valid clock
	input wire [LANES*SAMPLE_W-1:0]   sample_data,	// lane 0 in the low bits
	input wire apb_req_t              apb_req,
	output apb_rsp_t                  apb_rsp,
	output logic                      irq	// level, follows done
);

	// tree shape, widths grow by clog2 of each fan in
	localparam int S1_RED    = 4;
	localparam int S1_OUT_W  = SAMPLE_W + $clog2(S1_RED);
	localparam int S1_BLOCKS = (LANES + S1_RED - 1) / S1_RED;
	localparam int S2_RED    = S1_BLOCKS;	// second level folds everything left
	localparam int SUM_W     = S1_OUT_W + $clog2(S2_RED);

	logic                          s1_valid;
	logic [S1_OUT_W*S1_BLOCKS-1:0] s1_data;
	logic                          tree_valid;
	logic [SUM_W-1:0]              tree_sum;
	acc_ctrl_t                     acc_ctrl;
	acc_status_t                   acc_status;

	reduction_stage #(
		.IN_WORD_WIDTH (SAMPLE_W),
		.OUT_WORD_WIDTH(S1_OUT_W),
		.IN_BLOCKS     (LANES),
		.REDUCTION     (S1_RED)
	) u_stage1 (
		.clk       (clk),
		.rst       (rst),
		.en        (sample_valid),
		.din       (sample_data),
		.dout_valid(s1_valid),
		.dout      (s1_data)
	);

	reduction_stage #(
		.IN_WORD_WIDTH (S1_OUT_W),
		.OUT_WORD_WIDTH(SUM_W),
		.IN_BLOCKS     (S1_BLOCKS),
		.REDUCTION     (S2_RED)
	) u_stage2 (
		.clk       (clk),
		.rst       (rst),
		.en        (s1_valid),
		.din       (s1_data),
		.dout_valid(tree_valid),	// two clocks behind the sample beat
		.dout      (tree_sum)
	);

	beat_accumulator #(
		.SUM_W(SUM_W),
		.ACC_W(ACC_W)
	) u_acc (
		.clk       (clk),
		.rst       (rst),
		.tree_valid(tree_valid),
		.tree_sum  (tree_sum),
		.ctrl      (acc_ctrl),
		.status    (acc_status)
	);

	apb_regs u_regs (
		.clk    (clk),
		.rst    (rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.ctrl   (acc_ctrl),
		.status (acc_status)
	);

	assign irq = acc_status.done;

endmodule

`default_nettype wire

//--- test/tb_sum_engine.sv
`timescale 1ns/1ps
`default_nettype none

// self checking testbench for the streaming sum engine
module tb_sum_engine import sum_pkg::*;;

	localparam int LANES      = LANES_DEF;
	localparam int SAMPLE_W   = SAMPLE_W_DEF;
	localparam int ACC_W      = ACC_W_DEF;
	localparam int CLK_PERIOD = 40;
	localparam int SMALL_MAX  = 64;		// upper bound of the random target
	localparam int BIG_N      = 4200;	// enough all-ones beats to carry past bit 31
	localparam int MAX_BEATS  = 2*SMALL_MAX + 3 + 8 + 1 + BIG_N;	// gaps can double a run
	localparam int WATCHDOG_NS = (MAX_BEATS + 600) * CLK_PERIOD;	// margin covers APB traffic

	logic                      clk;
	logic                      rst;
	logic                      sample_valid;
	logic [LANES*SAMPLE_W-1:0] sample_data;
	apb_req_t                  apb_req;
	apb_rsp_t                  apb_rsp;
	logic                      irq;

	logic [LANES*SAMPLE_W-1:0] beat_q[$];	// beats of the current run, in send order
	int                        errors;
	int                        checks;

	// handoff between the sequence and the checker process
	bit               check_req;	// raised by the sequence, dropped by the checker
	logic [ACC_W-1:0] exp_result;
	logic [ACC_W-1:0] obs_result;
	logic [31:0]      exp_beats;
	logic [31:0]      obs_beats;
	logic [31:0]      exp_status;
	logic [31:0]      obs_status;

	sum_engine_top #(
		.LANES   (LANES),
		.SAMPLE_W(SAMPLE_W),
		.ACC_W   (ACC_W)
	) u_dut (
		.clk         (clk),
		.rst         (rst),
		.sample_valid(sample_valid),
		.sample_data (sample_data),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.irq         (irq)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD/2) clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run never reached its end", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	// every lane of every beat added on its own, no tree shape assumed
	function automatic logic [ACC_W-1:0] ref_sum();
		logic [ACC_W-1:0] total;
		int               l;
		total = '0;
		foreach (beat_q[b]) begin
			for (l = 0; l < LANES; l++) begin
				total = total + ACC_W'(beat_q[b][l*SAMPLE_W +: SAMPLE_W]);
			end
		end
		return total;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			$display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	// compares what the sequence read back against the model
	always begin
		wait (check_req);
		check_value("result", exp_result, obs_result);
		check_value("beats", exp_beats, obs_beats);
		check_value("status", exp_status, obs_status);
		check_req = 1'b0;
	end

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
		input logic exp_err);
		apb_req_t req;
		req        = '0;
		req.psel   = 1'b1;
		req.pwrite = 1'b1;
		req.paddr  = addr;
		req.pwdata = data;
		@(posedge clk);
		apb_req <= req;	// setup
		req.penable = 1'b1;
		@(posedge clk);
		apb_req <= req;	// access
		@(negedge clk);
		check_value("pslverr", exp_err, apb_rsp.pslverr);
		check_value("pready", 1'b1, apb_rsp.pready);
		@(posedge clk);
		apb_req <= '0;	// write lands on this edge
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
		input logic exp_err);
		apb_req_t req;
		req       = '0;
		req.psel  = 1'b1;
		req.paddr = addr;
		@(posedge clk);
		apb_req <= req;
		req.penable = 1'b1;
		@(posedge clk);
		apb_req <= req;
		@(negedge clk);	// prdata valid mid access cycle
		data = apb_rsp.prdata;
		check_value("pslverr", exp_err, apb_rsp.pslverr);
		check_value("pready", 1'b1, apb_rsp.pready);
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic drive_beat(input logic [LANES*SAMPLE_W-1:0] beat);
		@(posedge clk);
		sample_valid <= 1'b1;
		sample_data  <= beat;
	endtask

	// records each beat for the model, gaps are single idle cycles
	task automatic send_beats(input int n, input bit gaps, input bit ones);
		logic [LANES*SAMPLE_W-1:0] beat;
		int                        i;
		int                        l;
		for (i = 0; i < n; i++) begin
			if (gaps && $urandom_range(0, 3) == 0) begin
				@(posedge clk);
				sample_valid <= 1'b0;
			end
			if (ones) begin
				beat = '1;
			end else begin
				for (l = 0; l < LANES; l++) begin
					beat[l*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($urandom);
				end
			end
			beat_q.push_back(beat);
			drive_beat(beat);
		end
		@(posedge clk);
		sample_valid <= 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!irq && cycles < limit);
		if (!irq) begin
			$display("irq did not rise within %0d cycles of the last beat", limit);
			errors++;
		end
	endtask

	task automatic check_results(input logic [ACC_W-1:0] res, input logic [31:0] beats,
		input logic [31:0] status);
		logic [31:0] lo;
		logic [31:0] hi;
		apb_read(REG_RESULT_LO, lo, 1'b0);
		apb_read(REG_RESULT_HI, hi, 1'b0);
		apb_read(REG_BEATS, obs_beats, 1'b0);
		apb_read(REG_STATUS, obs_status, 1'b0);
		obs_result = {hi[ACC_W-33:0], lo};
		exp_result = res;
		exp_beats  = beats;
		exp_status = status;
		check_req = 1'b1;
		wait (!check_req);
	endtask

	task automatic start_run(input int target);
		apb_write(REG_TARGET, 32'(target), 1'b0);
		apb_write(REG_CTRL, 32'h1, 1'b0);
		beat_q.delete();
	endtask

	initial begin
		logic [31:0] rd;
		int          n;
		void'($urandom(32'h3332));
		errors       = 0;
		checks       = 0;
		rst          = 1'b1;
		sample_valid = 1'b0;
		sample_data  = '0;
		apb_req      = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// quiet state after reset
		@(negedge clk);
		check_value("irq", 1'b0, irq);
		check_results('0, 0, 0);
		apb_read(REG_TARGET, rd, 1'b0);
		check_value("target", 0, rd);

		// random run with idle gaps
		n = $urandom_range(1, SMALL_MAX);
		start_run(n);
		repeat (3) @(posedge clk);
		send_beats(n, 1'b1, 1'b0);
		wait_done(10);
		check_results(ref_sum(), n, 32'h2);	// done, not busy

		// beat after done is dropped, total stays
		drive_beat('1);
		@(posedge clk);
		sample_valid <= 1'b0;
		repeat (4) @(posedge clk);	// tree plus accumulate
		check_value("irq", 1'b1, irq);
		check_results(ref_sum(), n, 32'h6);	// overrun and done

		// start clears flags and total
		apb_write(REG_CTRL, 32'h1, 1'b0);
		beat_q.delete();
		check_results('0, 0, 32'h1);

		// restart mid run throws away the partial sum
		start_run(8);
		send_beats(3, 1'b0, 1'b0);
		repeat (4) @(posedge clk);	// nothing left in the tree
		apb_write(REG_CTRL, 32'h1, 1'b0);
		beat_q.delete();
		repeat (3) @(posedge clk);
		send_beats(8, 1'b1, 1'b0);
		wait_done(10);
		check_results(ref_sum(), 8, 32'h2);

		// zero target finishes at once
		start_run(0);
		@(negedge clk);
		check_value("irq", 1'b1, irq);
		check_results('0, 0, 32'h2);

		// full scale samples, carry reaches the high result word
		start_run(BIG_N);
		repeat (3) @(posedge clk);
		send_beats(BIG_N, 1'b0, 1'b1);
		wait_done(10);
		check_results(ref_sum(), BIG_N, 32'h2);

		// bad accesses get an error and change nothing
		apb_read(5'h18, rd, 1'b1);
		check_value("prdata", 0, rd);
		apb_write(REG_RESULT_LO, 32'hdead_beef, 1'b1);
		apb_write(5'h1C, 32'h1, 1'b1);
		apb_write(REG_STATUS, 32'h0, 1'b1);
		check_results(ref_sum(), BIG_N, 32'h2);
		apb_read(REG_TARGET, rd, 1'b0);
		check_value("target", BIG_N, rd);

		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sum_engine_top.f
hdl/sum_pkg.sv
hdl/reduction_stage.sv
hdl/beat_accumulator.sv
hdl/apb_regs.sv
hdl/sum_engine_top.sv
test/tb_sum_engine.sv

//--- Bender.yml
package:
  name: sum_engine

sources:
  - hdl/sum_pkg.sv
  - hdl/reduction_stage.sv
  - hdl/beat_accumulator.sv
  - hdl/apb_regs.sv
  - hdl/sum_engine_top.sv
  - target: test
    files:
      - test/tb_sum_engine.sv
